/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ############################################################
// core sizing
// ############################################################
`define WORD_SIZE 16       // data and address width
`define NUM_REGS  4        // general registers
`define RESET_PC  16'h0000 // first fetch address

`endif

/* cpuPkg.sv */
package cpuPkg;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcodeT;

    // codes 0..7 line up with the first eight alu operations
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26
    } functT;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR,
        ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR,
        ALU_PASSB, ALU_LHI, ALU_ORI
    } aluOpT;

    typedef enum logic [1:0] {ST_FETCH, ST_EXEC, ST_MEM, ST_WB} cpuStateT;

    typedef struct packed {
        logic  Jump;      // pc from 12-bit target
        logic  Branch;
        logic  MemtoReg;  // writeback from load data
        logic  RegDst;    // rd instead of rt
        logic  RegWrite;
        logic  ALUSrc;    // immediate as operand b
        logic  LinkWrite; // pc+1 into r2
        logic  PcFromReg; // pc from rs
        aluOpT aluOp;
        logic  irLoad;    // fetch in progress
        logic  pcUpdate;
    } ctrlT;

endpackage

/* memReqIf.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

interface memReqIf;

    logic                  readReq;
    logic                  writeReq;
    logic [`WORD_SIZE-1:0] address;
    logic [`WORD_SIZE-1:0] writeData;
    logic [`WORD_SIZE-1:0] readData;
    logic                  done;

    modport requester (
        output readReq, writeReq, address, writeData,
        input  readData, done
    );

    modport port (
        input  readReq, writeReq, address, writeData,
        output readData, done
    );

endinterface

/* memPort.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module memPort (
    input  logic                  clk,
    input  logic                  rstN,
    memReqIf.port                 mem,
    output logic                  readM,
    output logic                  writeM,
    output logic [`WORD_SIZE-1:0] address,
    output logic [`WORD_SIZE-1:0] dataOut,
    input  logic [`WORD_SIZE-1:0] dataIn,
    input  logic                  inputReady,
    input  logic                  ackOutput
);

    logic readDone;
    logic writeDone;

    assign readDone  = readM && inputReady;
    assign writeDone = writeM && ackOutput;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readM    <= 1'b0;
            writeM   <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= readDone || writeDone; // one cycle after the response
            if (mem.readReq) readM <= 1'b1;
            else if (readDone) readM <= 1'b0;
            if (mem.writeReq) writeM <= 1'b1;
            else if (writeDone) writeM <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.readReq || mem.writeReq) address <= mem.address;
        if (mem.writeReq) dataOut <= mem.writeData;
        if (readDone) mem.readData <= dataIn;
    end

    // ############################################################
    // bus checks
    // ############################################################
    assert property (@(posedge clk) disable iff (!rstN)
        (readM || writeM) && !(readDone || writeDone) |=> $stable(address) && $stable(dataOut));

    assert property (@(posedge clk) disable iff (!rstN)
        (readM || writeM || mem.done) |-> !(mem.readReq || mem.writeReq));

endmodule

/* regFile.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module regFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [$clog2(`NUM_REGS)-1:0]  readAddr1,
    input  logic [$clog2(`NUM_REGS)-1:0]  readAddr2,
    input  logic [$clog2(`NUM_REGS)-1:0]  writeAddr,
    input  logic [`WORD_SIZE-1:0]         writeData,
    input  logic                          writeEnable,
    output logic [`WORD_SIZE-1:0]         readData1,
    output logic [`WORD_SIZE-1:0]         readData2
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    assign readData1 = regs[readAddr1]; // combinational reads
    assign readData2 = regs[readAddr2];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

/* alu.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu (
    input  logic [`WORD_SIZE-1:0] a,
    input  logic [`WORD_SIZE-1:0] b,
    input  cpuPkg::aluOpT         op,
    output logic [`WORD_SIZE-1:0] result,
    output logic                  equal,
    output logic                  positive,
    output logic                  negative
);

    import cpuPkg::*;

    localparam int HALF = `WORD_SIZE / 2;

    always_comb begin
        case (op)
            ALU_ADD:   result = a + b; // wraps
            ALU_SUB:   result = a - b;
            ALU_AND:   result = a & b;
            ALU_ORR:   result = a | b;
            ALU_NOT:   result = ~a;
            ALU_TCP:   result = ~a + 1'b1;
            ALU_SHL:   result = {a[`WORD_SIZE-2:0], 1'b0};
            ALU_SHR:   result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]}; // arithmetic
            ALU_PASSB: result = b;
            ALU_LHI:   result = {b[HALF-1:0], {HALF{1'b0}}};
            ALU_ORI:   result = a | {{HALF{1'b0}}, b[HALF-1:0]}; // zero-extended imm
            default:   result = '0;
        endcase
    end

    // ############################################################
    // branch compare flags on operand a
    // ############################################################
    assign equal    = (a == b);
    assign negative = a[`WORD_SIZE-1];
    assign positive = !a[`WORD_SIZE-1] && (a != '0);

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::opcodeT  opcode,
    input  cpuPkg::functT   funct,
    output cpuPkg::ctrlT    ctrl,
    memReqIf.requester      mem
);

    import cpuPkg::*;

    cpuStateT state;
    logic     reqSent; // request out and awaiting done
    logic     isMemOp;

    assign isMemOp = (opcode == OP_LWD) || (opcode == OP_SWD);

    assign mem.readReq  = !reqSent && ((state == ST_FETCH)
                          || (state == ST_MEM && opcode == OP_LWD));
    assign mem.writeReq = !reqSent && state == ST_MEM && opcode == OP_SWD;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= ST_FETCH;
            reqSent <= 1'b0;
        end else begin
            if (mem.readReq || mem.writeReq) reqSent <= 1'b1;
            else if (mem.done) reqSent <= 1'b0;
            case (state)
                ST_FETCH: if (mem.done) state <= ST_EXEC;
                ST_EXEC:  state <= isMemOp ? ST_MEM : ST_FETCH;
                ST_MEM:   if (mem.done) state <= (opcode == OP_LWD) ? ST_WB : ST_FETCH;
                default:  state <= ST_FETCH;
            endcase
        end
    end

    // ############################################################
    // control word per state
    // ############################################################
    always_comb begin
        ctrl = '0;
        ctrl.aluOp = ALU_PASSB;
        case (state)
            ST_FETCH: ctrl.irLoad = 1'b1;
            ST_EXEC: begin
                ctrl.pcUpdate = 1'b1;
                case (opcode)
                    OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: ctrl.Branch = 1'b1;
                    OP_ADI, OP_ORI, OP_LHI: begin
                        ctrl.ALUSrc   = 1'b1;
                        ctrl.RegWrite = 1'b1;
                        ctrl.aluOp    = (opcode == OP_ADI) ? ALU_ADD :
                                        (opcode == OP_ORI) ? ALU_ORI : ALU_LHI;
                    end
                    OP_JMP: ctrl.Jump = 1'b1;
                    OP_JAL: begin
                        ctrl.Jump      = 1'b1;
                        ctrl.LinkWrite = 1'b1;
                        ctrl.RegWrite  = 1'b1;
                    end
                    OP_RTYPE: begin
                        case (funct)
                            FN_JPR: ctrl.PcFromReg = 1'b1;
                            FN_JRL: begin
                                ctrl.PcFromReg = 1'b1;
                                ctrl.LinkWrite = 1'b1;
                                ctrl.RegWrite  = 1'b1;
                            end
                            FN_ADD, FN_SUB, FN_AND, FN_ORR,
                            FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                                ctrl.RegDst   = 1'b1;
                                ctrl.RegWrite = 1'b1;
                                ctrl.aluOp    = aluOpT'(funct[3:0]);
                            end
                            default: ;
                        endcase
                    end
                    default: ; // unused codes fall through to pc+1
                endcase
            end
            ST_MEM: begin
                ctrl.ALUSrc = 1'b1; // rs + imm
                ctrl.aluOp  = ALU_ADD;
            end
            default: begin
                ctrl.RegWrite = 1'b1;
                ctrl.MemtoReg = 1'b1;
            end
        endcase
    end

    // done only answers a request still outstanding
    assert property (@(posedge clk) disable iff (!rstN) mem.done |-> reqSent);

endmodule

/* datapath.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module datapath (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::ctrlT    ctrl,
    output cpuPkg::opcodeT  opcode,
    output cpuPkg::functT   funct,
    memReqIf.requester      mem
);

    import cpuPkg::*;

    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] ir;
    logic [`WORD_SIZE-1:0] mdr; // load data held for writeback
    logic [`WORD_SIZE-1:0] pcPlus1;
    logic [`WORD_SIZE-1:0] nextPc;
    logic [`WORD_SIZE-1:0] immExt;
    logic [`WORD_SIZE-1:0] rsData;
    logic [`WORD_SIZE-1:0] rtData;
    logic [`WORD_SIZE-1:0] aluB;
    logic [`WORD_SIZE-1:0] aluResult;
    logic [`WORD_SIZE-1:0] wbData;
    logic [1:0]            rs;
    logic [1:0]            rt;
    logic [1:0]            rd;
    logic [1:0]            writeReg;
    logic                  aluEqual;
    logic                  aluPositive;
    logic                  aluNegative;
    logic                  branchTaken;

    // ############################################################
    // instruction fields
    // ############################################################
    assign opcode   = opcodeT'(ir[15:12]);
    assign funct    = functT'(ir[5:0]);
    assign rs       = ir[11:10];
    assign rt       = ctrl.LinkWrite ? 2'd2 : ir[9:8]; // link goes to r2
    assign rd       = ir[7:6];
    assign writeReg = ctrl.RegDst ? rd : rt;
    assign immExt   = {{8{ir[7]}}, ir[7:0]};

    assign aluB    = ctrl.ALUSrc ? immExt : rtData;
    assign pcPlus1 = pc + 1'b1;
    assign wbData  = ctrl.LinkWrite ? pcPlus1 : (ctrl.MemtoReg ? mdr : aluResult);

    regFile regs (
        .clk         (clk),
        .rstN        (rstN),
        .readAddr1   (rs),
        .readAddr2   (rt),
        .writeAddr   (writeReg),
        .writeData   (wbData),
        .writeEnable (ctrl.RegWrite),
        .readData1   (rsData),
        .readData2   (rtData)
    );

    alu aluUnit (
        .a        (rsData),
        .b        (aluB),
        .op       (ctrl.aluOp),
        .result   (aluResult),
        .equal    (aluEqual),
        .positive (aluPositive),
        .negative (aluNegative)
    );

    always_comb begin
        case (opcode)
            OP_BNE:  branchTaken = !aluEqual;
            OP_BEQ:  branchTaken = aluEqual;
            OP_BGZ:  branchTaken = aluPositive;
            OP_BLZ:  branchTaken = aluNegative;
            default: branchTaken = 1'b0;
        endcase
    end

    always_comb begin
        if (ctrl.PcFromReg) nextPc = rsData;
        else if (ctrl.Jump) nextPc = {pc[`WORD_SIZE-1 -: 4], ir[11:0]};
        else if (ctrl.Branch && branchTaken) nextPc = pcPlus1 + immExt;
        else nextPc = pcPlus1;
    end

    // fetch address in FETCH, rs + imm otherwise
    assign mem.address   = ctrl.irLoad ? pc : aluResult;
    assign mem.writeData = rtData;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `RESET_PC;
            ir <= '0;
        end else begin
            if (ctrl.pcUpdate) pc <= nextPc;
            if (ctrl.irLoad && mem.done) ir <= mem.readData;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.done) mdr <= mem.readData;
    end

endmodule

/* tscCpu.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tscCpu (
    input  logic                  clk,
    input  logic                  rstN,
    output logic                  readM,
    output logic                  writeM,
    output logic [`WORD_SIZE-1:0] address,
    output logic [`WORD_SIZE-1:0] dataOut,
    input  logic [`WORD_SIZE-1:0] dataIn,
    input  logic                  inputReady,
    input  logic                  ackOutput
);

    import cpuPkg::*;

    opcodeT opcode;
    functT  funct;
    ctrlT   ctrl;

    memReqIf memBus ();

    controlUnit ctrlUnit (
        .clk    (clk),
        .rstN   (rstN),
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl),
        .mem    (memBus.requester)
    );

    datapath dp (
        .clk    (clk),
        .rstN   (rstN),
        .ctrl   (ctrl),
        .opcode (opcode),
        .funct  (funct),
        .mem    (memBus.requester)
    );

    memPort port (
        .clk        (clk),
        .rstN       (rstN),
        .mem        (memBus.port),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .dataOut    (dataOut),
        .dataIn     (dataIn),
        .inputReady (inputReady),
        .ackOutput  (ackOutput)
    );

endmodule

/* tscCpuChecker.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tscCpuChecker (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  readM,
    input  logic                  writeM,
    input  logic [`WORD_SIZE-1:0] address,
    input  logic [`WORD_SIZE-1:0] dataOut,
    input  logic [`WORD_SIZE-1:0] dataIn,
    input  logic                  inputReady,
    input  logic                  ackOutput,
    output int                    instrCount,
    output int                    valueErrors,
    output int                    protocolErrors,
    output int                    timeouts,
    output logic                  finished
);

    localparam int INSTR_LIMIT = 2000;
    localparam int BUS_TIMEOUT = 50;  // cycles per bus transaction
    localparam int RESET_WAIT  = 100;

    localparam logic [3:0] BNE = 4'd0, BEQ = 4'd1, BGZ = 4'd2, BLZ = 4'd3;
    localparam logic [3:0] ADI = 4'd4, ORI = 4'd5, LHI = 4'd6, LWD = 4'd7;
    localparam logic [3:0] SWD = 4'd8, JMP = 4'd9, JAL = 4'd10, RTYPE = 4'd15;

    logic [15:0] regs [4];   // model state
    logic [15:0] pc;
    int          instrDone = 0;
    int          valueErrs = 0;
    int          protoErrs = 0;
    int          timeoutCount = 0;
    logic        modelFinished = 1'b0;
    logic        prevRead = 1'b0;
    logic        prevWrite = 1'b0;
    logic        prevResp = 1'b0;
    logic [15:0] prevAddr;
    logic [15:0] prevData;

    assign instrCount     = instrDone;
    assign valueErrors    = valueErrs;
    assign protocolErrors = protoErrs;
    assign timeouts       = timeoutCount;
    assign finished       = modelFinished;

    task automatic compareValue(input string name, input logic [15:0] got,
                                input logic [15:0] expected);
        if (got !== expected) begin
            $display("ERR %s got %h expected %h at instruction %0d",
                     name, got, expected, instrDone);
            valueErrs++;
        end
    endtask

    task automatic awaitStrobe(output bit ok);
        int n;
        n = 0;
        ok = 0;
        while (!ok && n < BUS_TIMEOUT) begin
            @(negedge clk);
            ok = readM || writeM;
            n++;
        end
        if (!ok) begin
            $display("Timeout: no bus strobe within %0d cycles", BUS_TIMEOUT);
            timeoutCount++;
        end
    endtask

    task automatic awaitResponse(output bit ok);
        int n;
        n = 0;
        ok = (readM && inputReady) || (writeM && ackOutput); // may come with the strobe
        while (!ok && n < BUS_TIMEOUT) begin
            @(negedge clk);
            ok = (readM && inputReady) || (writeM && ackOutput);
            n++;
        end
        if (!ok) begin
            $display("Timeout: strobe got no response within %0d cycles", BUS_TIMEOUT);
            timeoutCount++;
        end
    endtask

    task automatic busCycle(input bit isWrite, input logic [15:0] expAddr,
                            input logic [15:0] expData, output logic [15:0] rdata,
                            output bit ok);
        awaitStrobe(ok);
        rdata = '0;
        if (ok) begin
            compareValue("writeM", {15'd0, writeM}, {15'd0, isWrite});
            compareValue("address", address, expAddr);
            if (isWrite) compareValue("dataOut", dataOut, expData);
            awaitResponse(ok);
            rdata = dataIn;
        end
    endtask

    // ############################################################
    // instruction-level model
    // ############################################################
    task automatic stepInstruction(input logic [15:0] instr, output bit ok);
        logic [1:0]  rs;
        logic [1:0]  rt;
        logic [1:0]  rd;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] pcNext;
        logic [15:0] loaded;
        rs = instr[11:10];
        rt = instr[9:8];
        rd = instr[7:6];
        a = regs[rs];
        b = regs[rt];
        imm = {{8{instr[7]}}, instr[7:0]};
        pcNext = pc + 16'd1;
        ok = 1;
        case (instr[15:12])
            BNE: if (a != b) pcNext = pc + 16'd1 + imm;
            BEQ: if (a == b) pcNext = pc + 16'd1 + imm;
            BGZ: if ($signed(a) > 0) pcNext = pc + 16'd1 + imm;
            BLZ: if ($signed(a) < 0) pcNext = pc + 16'd1 + imm;
            ADI: regs[rt] = a + imm;
            ORI: regs[rt] = a | {8'h00, instr[7:0]};
            LHI: regs[rt] = {instr[7:0], 8'h00};
            LWD: begin
                busCycle(1'b0, a + imm, 16'h0000, loaded, ok);
                regs[rt] = loaded;
            end
            SWD: busCycle(1'b1, a + imm, b, loaded, ok);
            JMP: pcNext = {pc[15:12], instr[11:0]};
            JAL: begin
                pcNext = {pc[15:12], instr[11:0]};
                regs[2] = pc + 16'd1;  // link
            end
            RTYPE: begin
                case (instr[5:0])
                    6'd0:  regs[rd] = a + b;
                    6'd1:  regs[rd] = a - b;
                    6'd2:  regs[rd] = a & b;
                    6'd3:  regs[rd] = a | b;
                    6'd4:  regs[rd] = ~a;
                    6'd5:  regs[rd] = 16'd0 - a;
                    6'd6:  regs[rd] = a << 1;
                    6'd7:  regs[rd] = $signed(a) >>> 1;
                    6'd25: pcNext = a;
                    6'd26: begin
                        pcNext = a;          // target read before the link write
                        regs[2] = pc + 16'd1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
        pc = pcNext;
    endtask

    initial begin
        bit          ok;
        logic [15:0] instr;
        int          n;
        pc = `RESET_PC;
        for (int i = 0; i < 4; i++) begin
            regs[i] = '0;
        end
        n = 0;
        while (rstN !== 1'b1 && n < RESET_WAIT) begin
            @(negedge clk);
            n++;
        end
        ok = (rstN === 1'b1);
        if (!ok) begin
            $display("Timeout: reset was never released");
            timeoutCount++;
        end
        while (ok && instrDone < INSTR_LIMIT) begin
            busCycle(1'b0, pc, 16'h0000, instr, ok); // fetch
            if (ok) stepInstruction(instr, ok);
            if (ok) instrDone++;
        end
        modelFinished = 1'b1;
    end

    // ############################################################
    // bus protocol
    // ############################################################
    always @(negedge clk) begin
        if (rstN !== 1'b1) begin
            if (readM === 1'b1 || writeM === 1'b1) begin
                $display("Protocol: a strobe is high during reset");
                protoErrs++;
            end
            prevRead = 1'b0;
            prevWrite = 1'b0;
            prevResp = 1'b0;
        end else begin
            if (readM && writeM) begin
                $display("Protocol: readM and writeM are high together");
                protoErrs++;
            end
            if ((prevRead || prevWrite) && !prevResp) begin
                if (readM !== prevRead || writeM !== prevWrite) begin
                    $display("Protocol: strobe changed before its response");
                    protoErrs++;
                end
                if (address !== prevAddr) begin
                    $display("ERR address moved under strobe got %h expected %h",
                             address, prevAddr);
                    protoErrs++;
                end
                if (prevWrite && dataOut !== prevData) begin
                    $display("ERR dataOut moved under strobe got %h expected %h",
                             dataOut, prevData);
                    protoErrs++;
                end
            end
            if (prevResp && (readM || writeM)) begin
                $display("Protocol: strobe still high in the cycle after its response");
                protoErrs++;
            end
            prevRead = readM;
            prevWrite = writeM;
            prevAddr = address;
            prevData = dataOut;
            prevResp = (readM && inputReady) || (writeM && ackOutput);
        end
    end

endmodule

/* tscCpuTb.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tscCpuTb;

    localparam int RUN_LIMIT = 300000; // cycles for the whole run

    logic                  clk = 1'b0;
    logic                  rstN;
    logic                  readM;
    logic                  writeM;
    logic [`WORD_SIZE-1:0] address;
    logic [`WORD_SIZE-1:0] dataOut;
    logic [`WORD_SIZE-1:0] dataIn;
    logic                  inputReady;
    logic                  ackOutput;
    logic [15:0]           memory [65536];
    integer                seed;
    int                    instrCount;
    int                    valueErrors;
    int                    protocolErrors;
    int                    timeouts;
    logic                  finished;

    always #50 clk = ~clk;

    // legal opcodes only, a quarter of them loads and stores
    function automatic logic [15:0] randomInstruction(input logic [31:0] raw);
        logic [3:0] op;
        logic [5:0] fn;
        case (raw[19:16])
            4'd0, 4'd1:             op = 4'd7;  // LWD
            4'd2, 4'd3:             op = 4'd8;  // SWD
            4'd4, 4'd5, 4'd6, 4'd7: op = {2'b00, raw[17:16]}; // branches
            4'd8:                   op = 4'd4;
            4'd9:                   op = 4'd5;
            4'd10:                  op = 4'd6;
            4'd11:                  op = 4'd9;
            4'd12:                  op = 4'd10;
            default:                op = 4'd15;
        endcase
        fn = (raw[23] && raw[24]) ? (raw[22] ? 6'd26 : 6'd25) : {3'b000, raw[22:20]};
        if (op == 4'd15) return {op, raw[11:6], fn};
        return {op, raw[11:0]};
    endfunction

    // ############################################################
    // memory responder
    // ############################################################
    initial begin
        int waitLeft;
        bit busy;
        bit answered;
        seed = 77885;
        dataIn = '0;
        inputReady = 1'b0;
        ackOutput = 1'b0;
        busy = 0;
        answered = 0;
        waitLeft = 0;
        for (int i = 0; i < 65536; i++) begin
            memory[i] = randomInstruction($random(seed));
        end
        forever begin
            @(posedge clk);
            #1;
            inputReady = 1'b0;
            ackOutput = 1'b0;
            if (rstN !== 1'b1) begin
                busy = 0;
            end else if (!busy && !answered && (readM || writeM)) begin
                busy = 1;
                waitLeft = $unsigned($random(seed)) % 6; // 0..5 cycles
            end
            answered = 0;
            if (busy) begin
                if (waitLeft == 0) begin
                    if (readM) begin
                        dataIn = memory[address];
                        inputReady = 1'b1;
                    end else begin
                        memory[address] = dataOut;
                        ackOutput = 1'b1;
                    end
                    busy = 0;
                    answered = 1;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    tscCpu uut (
        .clk        (clk),
        .rstN       (rstN),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .dataOut    (dataOut),
        .dataIn     (dataIn),
        .inputReady (inputReady),
        .ackOutput  (ackOutput)
    );

    tscCpuChecker busCheck (
        .clk            (clk),
        .rstN           (rstN),
        .readM          (readM),
        .writeM         (writeM),
        .address        (address),
        .dataOut        (dataOut),
        .dataIn         (dataIn),
        .inputReady     (inputReady),
        .ackOutput      (ackOutput),
        .instrCount     (instrCount),
        .valueErrors    (valueErrors),
        .protocolErrors (protocolErrors),
        .timeouts       (timeouts),
        .finished       (finished)
    );

    initial begin
        int cycles;
        bit hung;
        rstN = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        cycles = 0;
        while (!finished && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        hung = !finished;
        if (hung) $display("Timeout: run did not complete within %0d cycles", RUN_LIMIT);
        $display("Instructions %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 instrCount, valueErrors, protocolErrors, timeouts);
        if (!hung && valueErrors == 0 && protocolErrors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* tscCpu.f */
+incdir+.
cpuPkg.sv
memReqIf.sv
memPort.sv
regFile.sv
alu.sv
controlUnit.sv
datapath.sv
tscCpu.sv
tscCpuChecker.sv
tscCpuTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tscCpuTb -f tscCpu.f -o tscCpuSim
simOutput=$(./obj_dir/tscCpuSim)
echo "$simOutput"

if grep -qx "Regression passed" <<< "$simOutput"; then
    exit 0
fi
exit 1
